// File: periph_pkg.sv
// 32-bit AXI4-Lite only; the window field is word address bits 15:8, so the LED window is byte 0x4000
package periph_pkg;

    // ----------------------------------------
    // bus widths
    localparam int AXIL_ADDR_WIDTH = 32;
    localparam int AXIL_DATA_WIDTH = 32;
    localparam int AXIL_STRB_WIDTH = 4;
    localparam int WB_DAT_SIZE     = 2;    // log2 bytes per word
    localparam int WB_ADR_WIDTH    = AXIL_ADDR_WIDTH - WB_DAT_SIZE;

    // ----------------------------------------
    // address windows
    localparam int WIN_LSB   = 8;
    localparam int WIN_WIDTH = 8;
    localparam logic [WIN_WIDTH-1:0] WIN_DMA0 = 8'h00;
    localparam logic [WIN_WIDTH-1:0] WIN_DMA1 = 8'h01;
    localparam logic [WIN_WIDTH-1:0] WIN_LED  = 8'h10;

    localparam int         LED_WIDTH = 3;
    localparam logic [1:0] RESP_OKAY = 2'b00;

    // ----------------------------------------
    // AXI4-Lite channels
    typedef struct packed {
        logic [AXIL_ADDR_WIDTH-1:0] addr;
        logic [2:0]                 prot;
    } axil_aw_t;

    typedef struct packed {
        logic [AXIL_DATA_WIDTH-1:0] data;
        logic [AXIL_STRB_WIDTH-1:0] strb;
    } axil_w_t;

    typedef struct packed {
        logic [1:0] resp;
    } axil_b_t;

    typedef struct packed {
        logic [AXIL_ADDR_WIDTH-1:0] addr;
        logic [2:0]                 prot;
    } axil_ar_t;

    typedef struct packed {
        logic [AXIL_DATA_WIDTH-1:0] data;
        logic [1:0]                 resp;
    } axil_r_t;

    // wishbone, single beat
    typedef struct packed {
        logic [WB_ADR_WIDTH-1:0]    adr;
        logic [AXIL_DATA_WIDTH-1:0] dat;
        logic                       we;
        logic [AXIL_STRB_WIDTH-1:0] sel;
        logic                       stb;
    } wb_req_t;

    typedef struct packed {
        logic [AXIL_DATA_WIDTH-1:0] dat;
        logic                       ack;
    } wb_rsp_t;

    typedef enum logic [2:0] {
        ST_IDLE,
        ST_WB_WRITE,
        ST_WB_READ,
        ST_B_RESP,
        ST_R_RESP
    } bridge_state_e;

endpackage

// File: axil_to_wb.sv
// one transaction in flight; prot is ignored, every response is OKAY, writes win over reads
module axil_to_wb (
    input  logic                  clk,
    input  logic                  resetn,

    input  periph_pkg::axil_aw_t  aw_i,
    input  logic                  aw_valid_i,
    output logic                  aw_ready_o,
    input  periph_pkg::axil_w_t   w_i,
    input  logic                  w_valid_i,
    output logic                  w_ready_o,
    output periph_pkg::axil_b_t   b_o,
    output logic                  b_valid_o,
    input  logic                  b_ready_i,
    input  periph_pkg::axil_ar_t  ar_i,
    input  logic                  ar_valid_i,
    output logic                  ar_ready_o,
    output periph_pkg::axil_r_t   r_o,
    output logic                  r_valid_o,
    input  logic                  r_ready_i,

    output periph_pkg::wb_req_t   wb_req_o,
    input  periph_pkg::wb_rsp_t   wb_rsp_i
);
    import periph_pkg::*;

    bridge_state_e              state_q;
    bridge_state_e              state_d;

    logic [WB_ADR_WIDTH-1:0]    adr_q;
    logic [AXIL_DATA_WIDTH-1:0] dat_q;
    logic [AXIL_STRB_WIDTH-1:0] sel_q;
    logic                       we_q;
    logic [AXIL_DATA_WIDTH-1:0] rdata_q;

    logic                       take_write;
    logic                       take_read;
    logic                       wb_stb;

    // ----------------------------------------
    // acceptance
    assign take_write = (state_q == ST_IDLE) && aw_valid_i && w_valid_i;
    assign take_read  = (state_q == ST_IDLE) && ar_valid_i && !(aw_valid_i && w_valid_i);

    assign aw_ready_o = take_write;
    assign w_ready_o  = take_write;   // aw and w go together
    assign ar_ready_o = take_read;

    // ----------------------------------------
    // state machine
    always_comb begin
        state_d = state_q;
        case (state_q)
            ST_IDLE: begin
                if (take_write) begin
                    state_d = ST_WB_WRITE;
                end else if (take_read) begin
                    state_d = ST_WB_READ;
                end
            end
            ST_WB_WRITE: begin
                if (wb_rsp_i.ack) begin
                    state_d = ST_B_RESP;
                end
            end
            ST_WB_READ: begin
                if (wb_rsp_i.ack) begin
                    state_d = ST_R_RESP;
                end
            end
            ST_B_RESP: begin
                if (b_ready_i) begin
                    state_d = ST_IDLE;
                end
            end
            ST_R_RESP: begin
                if (r_ready_i) begin
                    state_d = ST_IDLE;
                end
            end
            default: state_d = ST_IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!resetn) begin
            state_q <= ST_IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    // ----------------------------------------
    // request and read data capture
    always_ff @(posedge clk) begin
        if (take_write) begin
            adr_q <= aw_i.addr[AXIL_ADDR_WIDTH-1:WB_DAT_SIZE];
            dat_q <= w_i.data;
            sel_q <= w_i.strb;
            we_q  <= 1'b1;
        end else if (take_read) begin
            adr_q <= ar_i.addr[AXIL_ADDR_WIDTH-1:WB_DAT_SIZE];
            sel_q <= '1;                  // full word read
            we_q  <= 1'b0;
        end
        if (state_q == ST_WB_READ && wb_rsp_i.ack) begin
            rdata_q <= wb_rsp_i.dat;
        end
    end

    assign wb_stb = (state_q == ST_WB_WRITE) || (state_q == ST_WB_READ);  // held until ack

    assign wb_req_o = '{adr: adr_q, dat: dat_q, we: we_q, sel: sel_q, stb: wb_stb};

    // ----------------------------------------
    // responses, held until taken
    assign b_valid_o = (state_q == ST_B_RESP);
    assign b_o       = '{resp: RESP_OKAY};
    assign r_valid_o = (state_q == ST_R_RESP);
    assign r_o       = '{data: rdata_q, resp: RESP_OKAY};

endmodule

// File: wb_window_decode.sv
// only the LED window is mapped; every other window acks in the strobe cycle with zero data
module wb_window_decode (
    input  periph_pkg::wb_req_t wb_req_i,
    output periph_pkg::wb_rsp_t wb_rsp_o,
    output periph_pkg::wb_req_t led_req_o,
    input  periph_pkg::wb_rsp_t led_rsp_i
);
    import periph_pkg::*;

    logic [WIN_WIDTH-1:0] win;
    logic                 led_hit;

    assign win = wb_req_i.adr[WIN_LSB +: WIN_WIDTH];

    always_comb begin
        led_hit = 1'b0;
        case (win)
            WIN_DMA0, WIN_DMA1: led_hit = 1'b0;   // old dma windows, now empty
            WIN_LED:            led_hit = 1'b1;
            default:            led_hit = 1'b0;
        endcase
    end

    // strobe only reaches the selected slave
    always_comb begin
        led_req_o     = wb_req_i;
        led_req_o.stb = wb_req_i.stb && led_hit;
    end

    // ----------------------------------------
    // response mux
    always_comb begin
        if (led_hit) begin
            wb_rsp_o.dat = led_rsp_i.dat;
            wb_rsp_o.ack = led_rsp_i.ack;
        end else begin
            wb_rsp_o.dat = '0;
            wb_rsp_o.ack = wb_req_i.stb;      // unmapped, ack at once
        end
    end

endmodule

// File: led_regs.sv
// byte lane 0 write only; heartbeat period is 2**HEARTBEAT_BITS clocks, HEARTBEAT_BITS >= 1
module led_regs #(
    parameter int HEARTBEAT_BITS = 26
) (
    input  logic                clk,
    input  logic                resetn,
    input  periph_pkg::wb_req_t wb_req_i,
    output periph_pkg::wb_rsp_t wb_rsp_o,
    output logic [3:0]          led_o
);
    import periph_pkg::*;

    logic [LED_WIDTH-1:0]      led_q;
    logic [HEARTBEAT_BITS-1:0] beat_q;
    logic                      led_wr;

    // ----------------------------------------
    // LED register
    assign led_wr = wb_req_i.stb && wb_req_i.we && wb_req_i.sel[0];

    always_ff @(posedge clk) begin
        if (!resetn) begin
            led_q <= '0;
        end else if (led_wr) begin
            led_q <= wb_req_i.dat[LED_WIDTH-1:0];
        end
    end

    assign wb_rsp_o.dat = AXIL_DATA_WIDTH'(led_q);    // zero extended readback
    assign wb_rsp_o.ack = wb_req_i.stb;               // no wait states

    // ----------------------------------------
    // heartbeat
    always_ff @(posedge clk) begin
        if (!resetn) begin
            beat_q <= '0;
        end else begin
            beat_q <= beat_q + 1'b1;
        end
    end

    assign led_o = {beat_q[HEARTBEAT_BITS-1], led_q};

endmodule

// File: periph_top.sv
// AXI4-Lite peripheral slave with a single-outstanding bridge; HEARTBEAT_BITS sets the led 3 blink rate
module periph_top #(
    parameter int HEARTBEAT_BITS = 26
) (
    input  logic                  clk,
    input  logic                  resetn,

    input  periph_pkg::axil_aw_t  aw_i,
    input  logic                  aw_valid_i,
    output logic                  aw_ready_o,
    input  periph_pkg::axil_w_t   w_i,
    input  logic                  w_valid_i,
    output logic                  w_ready_o,
    output periph_pkg::axil_b_t   b_o,
    output logic                  b_valid_o,
    input  logic                  b_ready_i,
    input  periph_pkg::axil_ar_t  ar_i,
    input  logic                  ar_valid_i,
    output logic                  ar_ready_o,
    output periph_pkg::axil_r_t   r_o,
    output logic                  r_valid_o,
    input  logic                  r_ready_i,

    output logic [3:0]            led_o
);
    import periph_pkg::*;

    wb_req_t bus_req;
    wb_rsp_t bus_rsp;
    wb_req_t led_req;
    wb_rsp_t led_rsp;

    axil_to_wb u_bridge (
        .clk        (clk),
        .resetn     (resetn),
        .aw_i       (aw_i),
        .aw_valid_i (aw_valid_i),
        .aw_ready_o (aw_ready_o),
        .w_i        (w_i),
        .w_valid_i  (w_valid_i),
        .w_ready_o  (w_ready_o),
        .b_o        (b_o),
        .b_valid_o  (b_valid_o),
        .b_ready_i  (b_ready_i),
        .ar_i       (ar_i),
        .ar_valid_i (ar_valid_i),
        .ar_ready_o (ar_ready_o),
        .r_o        (r_o),
        .r_valid_o  (r_valid_o),
        .r_ready_i  (r_ready_i),
        .wb_req_o   (bus_req),
        .wb_rsp_i   (bus_rsp)
    );

    wb_window_decode u_decode (
        .wb_req_i  (bus_req),
        .wb_rsp_o  (bus_rsp),
        .led_req_o (led_req),
        .led_rsp_i (led_rsp)
    );

    led_regs #(
        .HEARTBEAT_BITS (HEARTBEAT_BITS)
    ) u_led (
        .clk      (clk),
        .resetn   (resetn),
        .wb_req_i (led_req),
        .wb_rsp_o (led_rsp),
        .led_o    (led_o)
    );

endmodule

// File: tb_periph_assertions.sv
// bound into axil_to_wb; handshake rules checked only while out of reset
module tb_periph_assertions (
    input logic                clk,
    input logic                resetn,
    input logic                aw_ready_o,
    input logic                w_ready_o,
    input logic                ar_ready_o,
    input periph_pkg::axil_b_t b_o,
    input logic                b_valid_o,
    input logic                b_ready_i,
    input periph_pkg::axil_r_t r_o,
    input logic                r_valid_o,
    input logic                r_ready_i,
    input periph_pkg::wb_req_t wb_req_o,
    input periph_pkg::wb_rsp_t wb_rsp_i
);

    b_hold: assert property (@(posedge clk) disable iff (!resetn)
        b_valid_o && !b_ready_i |=> b_valid_o && $stable(b_o))
        else $error("b channel dropped or changed under back-pressure");

    r_hold: assert property (@(posedge clk) disable iff (!resetn)
        r_valid_o && !r_ready_i |=> r_valid_o && $stable(r_o))
        else $error("r channel dropped or changed under back-pressure");

    stb_hold: assert property (@(posedge clk) disable iff (!resetn)
        wb_req_o.stb && !wb_rsp_i.ack |=> wb_req_o.stb && $stable(wb_req_o))
        else $error("wishbone request dropped before ack");

    // first cycle out of reset
    reset_quiet: assert property (@(posedge clk)
        $rose(resetn) |-> !aw_ready_o && !w_ready_o && !ar_ready_o
                          && !b_valid_o && !r_valid_o && !wb_req_o.stb)
        else $error("bridge output active right after reset");

endmodule

bind axil_to_wb tb_periph_assertions u_assert (
    .clk(clk), .resetn(resetn),
    .aw_ready_o(aw_ready_o), .w_ready_o(w_ready_o), .ar_ready_o(ar_ready_o),
    .b_o(b_o), .b_valid_o(b_valid_o), .b_ready_i(b_ready_i),
    .r_o(r_o), .r_valid_o(r_valid_o), .r_ready_i(r_ready_i),
    .wb_req_o(wb_req_o), .wb_rsp_i(wb_rsp_i)
);

// File: tb_periph_top.sv
// runs from the project root so tb_golden.txt is found; heartbeat modelled for a 6-bit counter
module tb_periph_top;
    import periph_pkg::*;

    localparam int          HB_BITS = 6;
    localparam logic [31:0] SEED    = 32'h7791_83da;

    typedef struct packed {
        logic        is_write;
        logic [31:0] addr;
        logic [31:0] data;
        logic [3:0]  strb;
        logic [7:0]  stall;
        logic [31:0] exp_rdata;
        logic [1:0]  exp_resp;
        logic [2:0]  exp_led;
    } golden_t;

    logic       clk;
    logic       resetn;
    axil_aw_t   aw;
    logic       aw_valid;
    logic       aw_ready;
    axil_w_t    w;
    logic       w_valid;
    logic       w_ready;
    axil_b_t    b;
    logic       b_valid;
    logic       b_ready;
    axil_ar_t   ar;
    logic       ar_valid;
    logic       ar_ready;
    axil_r_t    r;
    logic       r_valid;
    logic       r_ready;
    logic [3:0] led;

    golden_t     vectors[$];
    int          limit_cycles = 0;
    logic        beat_armed   = 1'b0;
    logic [31:0] beat_ref     = '0;
    logic        wr_fire_q    = 1'b0;
    logic        ar_fire_q    = 1'b0;
    logic        b_fire_q     = 1'b0;
    logic        r_fire_q     = 1'b0;

    periph_top #(.HEARTBEAT_BITS(HB_BITS)) u_dut (
        .clk(clk), .resetn(resetn),
        .aw_i(aw), .aw_valid_i(aw_valid), .aw_ready_o(aw_ready),
        .w_i(w), .w_valid_i(w_valid), .w_ready_o(w_ready),
        .b_o(b), .b_valid_o(b_valid), .b_ready_i(b_ready),
        .ar_i(ar), .ar_valid_i(ar_valid), .ar_ready_o(ar_ready),
        .r_o(r), .r_valid_o(r_valid), .r_ready_i(r_ready),
        .led_o(led)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // ----------------------------------------
    // handshakes seen at each edge, read back on the falling edge
    always @(posedge clk) begin
        wr_fire_q <= aw_valid && aw_ready && w_valid && w_ready;
        ar_fire_q <= ar_valid && ar_ready;
        b_fire_q  <= b_valid && b_ready;
        r_fire_q  <= r_valid && r_ready;
        if (!resetn) beat_ref <= '0;
        else         beat_ref <= beat_ref + 32'd1;   // clocks since release
    end

    always @(negedge clk) begin
        if (beat_armed) check_value("led_o[3]", {31'd0, beat_ref[HB_BITS-1]}, {31'd0, led[3]});
    end

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (actual !== expected) begin
            $display("** Error at time %0t: %s expected 0x%0h, actual 0x%0h",
                     $time, name, expected, actual);
            $display("ERRORS FOUND");
            $fatal(1);
        end
    endtask

    task automatic load_golden();
        int          fd;
        int          c;
        int          n;
        logic [31:0] f[7];
        golden_t     g;
        fd = $fopen("tb_golden.txt", "r");
        if (fd == 0) begin
            $display("could not open tb_golden.txt for reading");
            $display("ERRORS FOUND");
            $fatal(1);
        end
        c = $fgetc(fd);
        while (c != -1) begin
            if (c == "#") begin
                while (c != -1 && c != "\n") c = $fgetc(fd);   // skip comment line
            end else if (c == "W" || c == "R") begin
                n = $fscanf(fd, "%h %h %h %h %h %h %h", f[0], f[1], f[2], f[3], f[4], f[5], f[6]);
                if (n != 7) begin
                    $display("golden line %0d is incomplete", vectors.size() + 1);
                    $display("ERRORS FOUND");
                    $fatal(1);
                end
                g = '{is_write: (c == "W"), addr: f[0], data: f[1], strb: f[2][3:0],
                      stall: f[3][7:0], exp_rdata: f[4], exp_resp: f[5][1:0],
                      exp_led: f[6][2:0]};
                vectors.push_back(g);
            end
            c = $fgetc(fd);
        end
        $fclose(fd);
        if (vectors.size() == 0) begin
            $display("tb_golden.txt holds no transactions");
            $display("ERRORS FOUND");
            $fatal(1);
        end
    endtask

    // ----------------------------------------
    // one AXI4-Lite write, response held for g.stall cycles
    task automatic run_write(input golden_t g);
        int lat;
        repeat ($urandom % 3) @(negedge clk);
        aw       = '{addr: g.addr, prot: 3'b000};
        aw_valid = 1'b1;
        repeat ($urandom % 3) @(negedge clk);   // w may trail aw
        w        = '{data: g.data, strb: g.strb};
        w_valid  = 1'b1;
        @(negedge clk);
        while (!wr_fire_q) @(negedge clk);
        aw_valid = 1'b0;
        w_valid  = 1'b0;
        lat = 0;
        while (!b_valid) begin
            @(negedge clk);
            lat++;
        end
        check_value("b_valid_o latency", 1, lat);
        repeat (g.stall) begin
            check_value("b_o.resp", {30'd0, g.exp_resp}, {30'd0, b.resp});
            @(negedge clk);
            check_value("b_valid_o", 1, {31'd0, b_valid});
        end
        check_value("b_o.resp", {30'd0, g.exp_resp}, {30'd0, b.resp});
        b_ready = 1'b1;
        @(negedge clk);
        while (!b_fire_q) @(negedge clk);
        b_ready = 1'b0;
        check_value("led_o[2:0]", {29'd0, g.exp_led}, {29'd0, led[2:0]});
    endtask

    task automatic run_read(input golden_t g);
        int lat;
        repeat ($urandom % 3) @(negedge clk);
        ar       = '{addr: g.addr, prot: 3'b000};
        ar_valid = 1'b1;
        @(negedge clk);
        while (!ar_fire_q) @(negedge clk);
        ar_valid = 1'b0;
        lat = 0;
        while (!r_valid) begin
            @(negedge clk);
            lat++;
        end
        check_value("r_valid_o latency", 1, lat);
        repeat (g.stall) begin
            check_value("r_o.data", g.exp_rdata, r.data);
            @(negedge clk);
            check_value("r_valid_o", 1, {31'd0, r_valid});
        end
        check_value("r_o.data", g.exp_rdata, r.data);
        check_value("r_o.resp", {30'd0, g.exp_resp}, {30'd0, r.resp});
        r_ready = 1'b1;
        @(negedge clk);
        while (!r_fire_q) @(negedge clk);
        r_ready = 1'b0;
        check_value("led_o[2:0]", {29'd0, g.exp_led}, {29'd0, led[2:0]});
    endtask

    // ----------------------------------------
    initial begin
        resetn   = 1'b0;
        aw       = '0;
        aw_valid = 1'b0;
        w        = '0;
        w_valid  = 1'b0;
        b_ready  = 1'b0;
        ar       = '0;
        ar_valid = 1'b0;
        r_ready  = 1'b0;
        void'($urandom(SEED));
        load_golden();
        limit_cycles = 40 * vectors.size() + 100;
        repeat (8) @(posedge clk);
        beat_armed = 1'b1;
        @(negedge clk);
        resetn = 1'b1;
        @(negedge clk);
        foreach (vectors[i]) begin
            if (vectors[i].is_write) run_write(vectors[i]);
            else                     run_read(vectors[i]);
        end
        $display("NO ERRORS");
        $finish;
    end

    // watchdog
    initial begin
        wait (limit_cycles > 0);
        repeat (limit_cycles) @(posedge clk);
        $display("timeout: %0d transactions did not finish within %0d cycles",
                 vectors.size(), limit_cycles);
        $display("ERRORS FOUND");
        $fatal(1);
    end

endmodule

// File: tb_golden.txt
# kind (W write, R read), byte addr, data, strb, stall cycles, exp rdata, exp resp, exp led[2:0]
# all numbers hex; the LED window is byte address 0x4000
R 00004000 00000000 0 0 00000000 0 0
W 00004000 00000005 1 0 00000000 0 5
R 00004000 00000000 0 0 00000005 0 5
W 00004000 000000fa f 2 00000000 0 2
R 00004000 00000000 0 3 00000002 0 2
# strobe bit 0 clear, LEDs keep their value
W 00004000 00000007 e 0 00000000 0 2
R 00004000 00000000 0 1 00000002 0 2
# unmapped windows
W 00000000 00000007 f 0 00000000 0 2
R 00000000 00000000 0 0 00000000 0 2
W 00000400 00000003 f 4 00000000 0 2
R 00000400 00000000 0 2 00000000 0 2
W 00008000 00000001 f 0 00000000 0 2
R 00008000 00000000 0 5 00000000 0 2
# other words inside the LED window
W 0000400c 00000006 1 1 00000000 0 6
R 00004000 00000000 0 0 00000006 0 6
W 00004000 00000001 3 3 00000000 0 1
R 00004004 00000000 0 0 00000001 0 1
W 00004000 00000000 1 0 00000000 0 0
R 00004000 00000000 0 2 00000000 0 0

// File: build.f
periph_pkg.sv
axil_to_wb.sv
wb_window_decode.sv
led_regs.sv
periph_top.sv
tb_periph_assertions.sv
tb_periph_top.sv

// File: Makefile
VERILATOR := verilator
VFLAGS    := --binary --timing --assert -Wno-fatal
TOP       := tb_periph_top
FILELIST  := build.f
OBJ_DIR   := obj_dir

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# exit status of the simulation is the test result
run: compile
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)
